// File: Bender.yml
package:
  name: ma_sqr

sources:
  - verilog/ma_sqr_pkg.sv
  - verilog/ma_sqr_fsm.sv
  - verilog/ma_sqr_opsel.sv
  - verilog/ma_sqr_wrback.sv
  - verilog/ma_sqr_top.sv
  - target: test
    files:
      - dv/ma_sqr_assert.sv
      - dv/tb_ma_sqr.sv

// File: dv/ma_sqr_assert.sv
// bound checks on the squaring sequencer top level
// the state may read all zero between two states, so at most one bit is set
`timescale 1ns/1ps

module ma_sqr_assert (
        input  logic rclk,
        input  logic rst_n,
        input  ma_sqr_pkg::sqr_state_t state,
        input  logic mul_req_vld,
        input  logic memren,
        input  logic memwen
);

        // ------------------------------
        // state register
        // ------------------------------
        // one-hot, or empty during a delayed transition
        state_onehot0: assert property (@(posedge rclk) disable iff (!rst_n)
                $onehot0(state))
                else $error("state register has more than one bit set");

        // no multiply request may leave idle
        req_not_idle: assert property (@(posedge rclk) disable iff (!rst_n)
                (state == ma_sqr_pkg::s_idle) |-> !mul_req_vld)
                else $error("multiply request raised in idle");

        // ------------------------------
        // memory port
        // ------------------------------
        // single port memory, read and write never share a cycle
        mem_rw_excl: assert property (@(posedge rclk) disable iff (!rst_n)
                !(memren && memwen))
                else $error("memory read and write enabled together");

endmodule

bind ma_sqr_top ma_sqr_assert assert_i (
        .rclk        (rclk),
        .rst_n       (rst_n),
        .state       (state),
        .mul_req_vld (mul_req_vld),
        .memren      (memren),
        .memwen      (memwen)
);

// File: dv/ma_sqr_tests.txt
# columns: len  ack_delay  kill_cycle (0 means no kill)
# ack_delay is in cycles, the testbench adds 0 to 3 random cycles
1 1 0
2 2 0
3 1 0
2 40 0
3 2 60
3 1 0
4 3 0
2 1 5
1 2 0
4 1 0

// File: dv/tb_ma_sqr.sv
// testbench for the squaring sequencer with pointer unit and multiplier models
// stimulus lines come from dv/ma_sqr_tests.txt, run from the project root
// the pointer model also clears on kill_op, like the real pointer unit
`timescale 1ns/1ps

module tb_ma_sqr;

        localparam int DONE_TIMEOUT = 50000;

        logic rclk, rst_n, kill_op, mulop, iss_pulse_dly, aequb;
        logic iequtwolenplus2, iequtwolenplus1, iequtwolen, ieven, ieq0;
        logic jequiminus1, jequiminus1rshft, jequlen, halfpnt_set;
        logic mul_ack, mul_shf_ack;
        logic memren, memwen, rst_iptr, rst_jptr, incr_iptr, incr_jptr;
        logic a_rd_sel, m_rd_sel, n_rd_sel, m_wr_sel;
        logic iminus1_ptr_sel, j_ptr_sel, iminusj_ptr_sel, iminuslenminus1_sel, irshft_sel;
        logic jjptr_wen, jjptr_sel, oprnd2_wen, oprnd2_bypass, a_leftshft, oprnd1_wen;
        ma_sqr_pkg::op1_sel_t oprnd1_mxsel;
        logic mul_req_vld, mul_areg_shf, mul_acc, mul_areg_rst, mul_done;
        logic [25:0] ctl_bits;

        integer seed;
        int cur_len, ack_dly, i_ptr, j_ptr, ack_cnt, ack_tgt;
        int incr_cnt, memwen_cnt, done_cnt, arst_cnt;
        logic pend_incr_i, pend_rst_i, pend_incr_j, pend_rst_j;
        logic pend_req, pend_shf, pend_kill, prev_incr;

        ma_sqr_top dut_i (.*);

        // every control output except the operand-1 mux select
        assign ctl_bits = {memren, memwen, rst_iptr, rst_jptr, incr_iptr, incr_jptr,
                           a_rd_sel, m_rd_sel, n_rd_sel, m_wr_sel, iminus1_ptr_sel,
                           j_ptr_sel, iminusj_ptr_sel, iminuslenminus1_sel, irshft_sel,
                           jjptr_wen, jjptr_sel, oprnd2_wen, oprnd2_bypass, a_leftshft,
                           oprnd1_wen, mul_req_vld, mul_areg_shf, mul_acc, mul_areg_rst,
                           mul_done};

        initial begin
                rclk = 1'b0;
                forever #50 rclk = ~rclk;
        end

        // ------------------------------
        // reporting
        // ------------------------------
        task automatic stop_with_failure(input string why);
                $display("%s", why);
                $display("sim failed");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp)
                        stop_with_failure($sformatf("mismatch %s got 0x%0h expected 0x%0h",
                                                    name, got, exp));
        endtask

        // pointer flags from the model's i and j
        task automatic drive_flags();
                iequtwolenplus2  = (i_ptr == 2 * cur_len + 2);
                iequtwolenplus1  = (i_ptr == 2 * cur_len + 1);
                iequtwolen       = (i_ptr == 2 * cur_len);
                ieven            = (i_ptr % 2 == 0);
                ieq0             = (i_ptr == 0);
                jequiminus1      = (j_ptr == i_ptr - 1);
                jequiminus1rshft = (i_ptr > 0) && (j_ptr == (i_ptr - 1) / 2);
                jequlen          = (j_ptr == cur_len);
                halfpnt_set      = (i_ptr > cur_len);
        endtask

        // ------------------------------
        // pointer unit and multiplier models
        // ------------------------------
        // strobes sampled mid-cycle take effect at the next falling edge
        initial begin
                forever begin
                        @(negedge rclk);
                        if (pend_kill) begin
                                i_ptr = 0;
                                j_ptr = 0;
                        end else begin
                                if (pend_rst_i)
                                        i_ptr = 0;
                                else if (pend_incr_i)
                                        i_ptr++;
                                if (pend_rst_j)
                                        j_ptr = 0;
                                else if (pend_incr_j)
                                        j_ptr++;
                        end
                        // one-cycle ack after the delay plus 0 to 3 random cycles
                        if (pend_kill || mul_ack) begin
                                mul_ack = 1'b0;
                                ack_cnt = 0;
                        end else if (pend_req) begin
                                if (ack_cnt == 0)
                                        ack_tgt = ack_dly + ({$random(seed)} % 4);
                                ack_cnt++;
                                if (ack_cnt >= ack_tgt)
                                        mul_ack = 1'b1;
                        end
                        mul_shf_ack = pend_shf & ~pend_kill;
                        drive_flags();
                        #10;
                        // waiting on the multiplier, request held and no write
                        if (ack_cnt > 0 && !mul_ack) begin
                                check_value("mul_req_vld", mul_req_vld, 1);
                                check_value("memwen", memwen, 0);
                        end
                        check_value("memwen", memwen, prev_incr);
                        if (memwen) begin
                                check_value("m_wr_sel", m_wr_sel, 1);
                                check_value("iminuslenminus1_sel", iminuslenminus1_sel,
                                            halfpnt_set);
                                check_value("iminus1_ptr_sel", iminus1_ptr_sel, !halfpnt_set);
                        end
                        if (rst_iptr)
                                check_value("i_ptr", i_ptr, 2 * cur_len + 2);
                        incr_cnt   += incr_iptr;
                        memwen_cnt += memwen;
                        done_cnt   += mul_done;
                        arst_cnt   += mul_areg_rst;
                        prev_incr   = incr_iptr & ~kill_op;
                        pend_incr_i = incr_iptr;
                        pend_rst_i  = rst_iptr;
                        pend_incr_j = incr_jptr;
                        pend_rst_j  = rst_jptr;
                        pend_req    = mul_req_vld;
                        pend_shf    = mul_areg_shf;
                        pend_kill   = kill_op;
                end
        end

        // ------------------------------
        // one operation per test line
        // ------------------------------
        task automatic run_test(input int len, input int dly, input int kill_at);
                int cyc;
                @(negedge rclk);
                cur_len    = len;
                ack_dly    = dly;
                incr_cnt   = 0;
                memwen_cnt = 0;
                done_cnt   = 0;
                arst_cnt   = 0;
                @(negedge rclk);
                mulop         = 1'b1;
                iss_pulse_dly = 1'b1;
                #10;
                check_value("mul_areg_rst", mul_areg_rst, 1);
                @(negedge rclk);
                iss_pulse_dly = 1'b0;
                if (kill_at > 0) begin
                        repeat (kill_at) @(negedge rclk);
                        if (done_cnt != 0)
                                stop_with_failure("operation ended before the kill cycle");
                        kill_op = 1'b1;
                        @(negedge rclk);
                        kill_op = 1'b0;
                        #10;
                        check_value("controls after kill", ctl_bits, 0);
                        check_value("oprnd1_mxsel after kill", oprnd1_mxsel, 0);
                        repeat (20) @(negedge rclk);
                        check_value("mul_done count after kill", done_cnt, 0);
                end else begin
                        cyc = 0;
                        while (done_cnt == 0) begin
                                @(negedge rclk);
                                cyc++;
                                if (cyc > DONE_TIMEOUT)
                                        stop_with_failure("mul_done never came");
                        end
                        repeat (4) @(negedge rclk);
                        check_value("mul_done count", done_cnt, 1);
                        check_value("mul_areg_rst count", arst_cnt, 1);
                        check_value("incr_iptr count", incr_cnt, 2 * len + 2);
                        check_value("memwen count", memwen_cnt, 2 * len + 2);
                end
                mulop = 1'b0;
        endtask

        initial begin
                int fd, len, dly, kill_at;
                string line;
                seed = 32'he0f8_1a78;
                {rst_n, kill_op, mulop, iss_pulse_dly, aequb} = '0;
                {mul_ack, mul_shf_ack} = '0;
                {i_ptr, j_ptr, ack_cnt, ack_tgt, cur_len, ack_dly} = '0;
                {incr_cnt, memwen_cnt, done_cnt, arst_cnt} = '0;
                {pend_incr_i, pend_rst_i, pend_incr_j, pend_rst_j} = '0;
                {pend_req, pend_shf, pend_kill, prev_incr} = '0;
                drive_flags();
                repeat (4) @(negedge rclk);
                rst_n = 1'b1;
                aequb = 1'b1;
                // quiet before any start
                repeat (5) begin
                        @(negedge rclk);
                        #10;
                        check_value("controls after reset", ctl_bits, 0);
                        check_value("oprnd1_mxsel", oprnd1_mxsel, 0);
                end
                fd = $fopen("dv/ma_sqr_tests.txt", "r");
                if (fd == 0)
                        stop_with_failure("cannot open dv/ma_sqr_tests.txt");
                while (!$feof(fd)) begin
                        if ($fgets(line, fd) != 0) begin
                                if (line.len() > 0 && line[0] != "#") begin
                                        if ($sscanf(line, "%d %d %d", len, dly, kill_at) == 3)
                                                run_test(len, dly, kill_at);
                                end
                        end
                end
                $fclose(fd);
                $display("sim passed");
                $finish;
        end

        // overall cycle limit
        initial begin
                repeat (400000) @(posedge rclk);
                stop_with_failure("simulation ran past its cycle limit");
        end

endmodule

// File: project.f
verilog/ma_sqr_pkg.sv
verilog/ma_sqr_fsm.sv
verilog/ma_sqr_opsel.sv
verilog/ma_sqr_wrback.sv
verilog/ma_sqr_top.sv
dv/ma_sqr_assert.sv
dv/tb_ma_sqr.sv

// File: verilog/ma_sqr_fsm.sv
// execute stage, one-hot loop FSM of the squaring and reduction
// state reads all zero during the single cycle of a delayed transition
// and while a product travels the result delay line
// mul_req_vld holds until mul_ack, no limit on back-pressure
`timescale 1ns/1ps

module ma_sqr_fsm (
        input  logic rclk,
        input  logic rst_n,
        input  logic kill_op,
        input  logic mulop,
        input  logic iss_pulse_dly,
        input  logic aequb,
        input  logic iequtwolenplus2, iequtwolenplus1, iequtwolen,
        input  logic ieven, ieq0,
        input  logic jequiminus1, jequiminus1rshft, jequlen,
        input  logic halfpnt_set,
        input  logic mul_ack,
        input  logic mul_shf_ack,
        input  logic mwrite_next,
        output ma_sqr_pkg::sqr_state_t state,
        output logic rd_aj, rd_aiminusj, rd_ai, rd_mj, rd_niminusj, rd_n0,
        output logic iloopa1_dly, oprnd2_load,
        output logic jloopn_final, nprime_ack, accum_enter, accum_done,
        output logic rst_jptr, incr_jptr, jjptr_wen, jjptr_sel,
        output logic a_leftshft,
        output logic mul_req_vld, mul_acc, mul_areg_shf, mul_areg_rst
);

        logic [10:0] cur_q, nxt_d;
        logic [8:0]  dly_q, dly_d;
        logic aequb_q, mulop_start, jloopn_more, accum_pulse, mul_req_pre;
        logic cur_idle, cur_jloopa, cur_ijloopa, cur_iloopa1, cur_iloopa, cur_jloopm;
        logic cur_jloopn, cur_nprime, cur_mwrite, cur_iloopn, cur_accumshft;
        logic nxt_idle, nxt_jloopa, nxt_ijloopa, nxt_iloopa1, nxt_iloopa, nxt_jloopm;
        logic nxt_jloopn, nxt_nprime, nxt_mwrite, nxt_iloopn, nxt_accumshft;
        logic tr2jloopa_frm_ijloopa, tr2jloopa_frm_accumshft, tr2jloopa_frm_accumshft_dly;
        logic tr2iloopa1_frm_ijloopa, tr2iloopa1_frm_accumshft, tr2iloopa1_frm_accumshft_dly;
        logic tr2iloopa1_frm_idle, tr2iloopa1_frm_idle_dly;
        logic tr2jloopm_frm_ijloopa, tr2jloopm_frm_ijloopa_dly;
        logic tr2jloopm_frm_iloopa, tr2jloopm_frm_iloopa_dly, tr2jloopm_frm_jloopn;
        logic tr2nprime_frm_jloopn, tr2nprime_frm_jloopn_dly, tr2nprime_frm_iloopa;
        logic tr2accumshft_frm_mwrite, tr2accumshft_frm_iloopn, cur_accumshft_q;

        // ------------------------------
        // state and delay registers
        // ------------------------------
        assign nxt_d = {nxt_accumshft, nxt_iloopn, nxt_mwrite, nxt_nprime, nxt_jloopn,
                        nxt_jloopm, nxt_iloopa, nxt_iloopa1, nxt_ijloopa, nxt_jloopa, nxt_idle};
        assign {cur_accumshft, cur_iloopn, cur_mwrite, cur_nprime, cur_jloopn,
                cur_jloopm, cur_iloopa, cur_iloopa1, cur_ijloopa, cur_jloopa, cur_idle} = cur_q;
        assign state = ma_sqr_pkg::sqr_state_t'(cur_q);

        // one-cycle transition delays, registered request, accumshft edge detect
        assign dly_d = {tr2jloopa_frm_accumshft, tr2iloopa1_frm_accumshft, tr2iloopa1_frm_idle,
                        cur_iloopa1, tr2jloopm_frm_ijloopa, tr2jloopm_frm_iloopa,
                        tr2nprime_frm_jloopn, mul_req_pre, cur_accumshft};
        assign {tr2jloopa_frm_accumshft_dly, tr2iloopa1_frm_accumshft_dly,
                tr2iloopa1_frm_idle_dly, iloopa1_dly, tr2jloopm_frm_ijloopa_dly,
                tr2jloopm_frm_iloopa_dly, tr2nprime_frm_jloopn_dly, mul_req_vld,
                cur_accumshft_q} = dly_q;

        always_ff @(posedge rclk or negedge rst_n) begin
                if (!rst_n) begin
                        cur_q   <= ma_sqr_pkg::s_idle;
                        dly_q   <= '0;
                        aequb_q <= 1'b0;
                end else begin
                        aequb_q <= aequb;
                        // kill drops everything back to idle
                        if (kill_op) begin
                                cur_q <= ma_sqr_pkg::s_idle;
                                dly_q <= '0;
                        end else begin
                                cur_q <= nxt_d;
                                dly_q <= dly_d;
                        end
                end
        end

        // ------------------------------
        // idle
        // ------------------------------
        assign mulop_start  = iss_pulse_dly & mulop & aequb_q;
        assign mul_areg_rst = mulop_start;
        // last accumulate shift with i at 2len+2 ends the op
        assign accum_done   = cur_accumshft & iequtwolenplus2 & mul_shf_ack;
        assign nxt_idle     = accum_done | (cur_idle & ~mulop_start);

        // ------------------------------
        // a-side inner loop
        // ------------------------------
        assign tr2jloopa_frm_ijloopa   = cur_ijloopa & mul_ack & ~jequiminus1rshft;
        assign tr2jloopa_frm_accumshft = cur_accumshft & mul_shf_ack & ~iequtwolenplus2 &
                                         ~iequtwolenplus1 & ~iequtwolen;
        assign nxt_jloopa  = tr2jloopa_frm_ijloopa | tr2jloopa_frm_accumshft_dly;
        assign rd_aj       = (cur_ijloopa & ~jequiminus1rshft) | tr2jloopa_frm_accumshft_dly;
        assign nxt_ijloopa = cur_jloopa | (cur_ijloopa & ~mul_ack);
        assign rd_aiminusj = cur_jloopa;
        // cross products are doubled by shifting A left
        assign a_leftshft  = cur_ijloopa;

        // square term, i even only
        assign tr2iloopa1_frm_ijloopa   = cur_ijloopa & mul_ack & ieven & jequiminus1rshft;
        assign tr2iloopa1_frm_accumshft = cur_accumshft & mul_shf_ack & ieven &
                                          (iequtwolenplus1 | iequtwolen);
        assign tr2iloopa1_frm_idle      = cur_idle & mulop_start;
        assign nxt_iloopa1 = tr2iloopa1_frm_accumshft_dly | tr2iloopa1_frm_ijloopa |
                             tr2iloopa1_frm_idle_dly;
        assign nxt_iloopa  = iloopa1_dly | (cur_iloopa & ~mul_ack);
        assign rd_ai = (cur_ijloopa & ieven & jequiminus1rshft) | tr2iloopa1_frm_idle_dly |
                       tr2iloopa1_frm_accumshft_dly | iloopa1_dly;

        // ------------------------------
        // reduction loop
        // ------------------------------
        // more jloopn passes: j below i-1 in the first half, below len in the second
        assign jloopn_more = (~jequiminus1 & ~halfpnt_set) | (~jequlen & halfpnt_set);
        assign tr2jloopm_frm_ijloopa = cur_ijloopa & mul_ack & ~ieven & jequiminus1rshft;
        assign tr2jloopm_frm_iloopa  = cur_iloopa & mul_ack & ~ieq0;
        assign tr2jloopm_frm_jloopn  = cur_jloopn & mul_ack & jloopn_more;
        assign nxt_jloopm = tr2jloopm_frm_jloopn | tr2jloopm_frm_ijloopa_dly |
                            tr2jloopm_frm_iloopa_dly;
        assign rd_mj = tr2jloopm_frm_ijloopa_dly | tr2jloopm_frm_iloopa_dly |
                       (cur_jloopn & jloopn_more);
        assign nxt_jloopn  = cur_jloopm | (cur_jloopn & ~mul_ack);
        assign rd_niminusj = cur_jloopm;
        // second-half exit goes through the result delay line
        assign jloopn_final = cur_jloopn & mul_ack & halfpnt_set & jequlen;

        // j pointer controls
        assign jjptr_wen = cur_jloopa | cur_jloopm;
        assign jjptr_sel = cur_ijloopa | cur_jloopn;
        assign incr_jptr = tr2jloopa_frm_ijloopa | tr2jloopm_frm_jloopn;

        // n-prime multiply, first half only
        assign tr2nprime_frm_jloopn = cur_jloopn & mul_ack & jequiminus1 & ~halfpnt_set;
        assign tr2nprime_frm_iloopa = cur_iloopa & mul_ack & ieq0;
        assign nxt_nprime = tr2nprime_frm_jloopn | tr2nprime_frm_iloopa | (cur_nprime & ~mul_ack);
        assign nprime_ack = cur_nprime & mul_ack;

        // ------------------------------
        // write, N[0] and shift
        // ------------------------------
        assign nxt_mwrite = mwrite_next;
        assign nxt_iloopn = (cur_mwrite & ~halfpnt_set) | (cur_iloopn & ~mul_ack);
        assign rd_n0      = cur_mwrite;

        assign tr2accumshft_frm_mwrite = cur_mwrite & halfpnt_set;
        assign tr2accumshft_frm_iloopn = cur_iloopn & mul_ack;
        assign accum_enter   = tr2accumshft_frm_mwrite | tr2accumshft_frm_iloopn;
        assign nxt_accumshft = accum_enter | (cur_accumshft & ~mul_shf_ack);
        assign mul_areg_shf  = cur_accumshft;
        assign accum_pulse   = cur_accumshft & ~cur_accumshft_q;

        // j restarts on start, on each new reduction pass and on second-half shifts
        assign rst_jptr = mulop_start | tr2nprime_frm_jloopn_dly | tr2jloopm_frm_ijloopa |
                          tr2iloopa1_frm_ijloopa |
                          (accum_pulse & halfpnt_set & ~iequtwolenplus2 & ~iequtwolenplus1);

        // ------------------------------
        // multiplier and operand 2
        // ------------------------------
        assign mul_req_pre = nxt_ijloopa | nxt_jloopn | nxt_nprime | nxt_iloopn | nxt_iloopa;
        // n-prime product starts a fresh result
        assign mul_acc     = mul_req_vld & ~cur_nprime;
        assign oprnd2_load = nxt_jloopa | nxt_iloopa1 | nxt_jloopm;

endmodule

// File: verilog/ma_sqr_opsel.sv
// decode stage, memory and pointer selects from the read and write strobes
// operand registers load one cycle after the memory read
`timescale 1ns/1ps

module ma_sqr_opsel (
        input  logic rclk,
        input  logic rst_n,
        input  ma_sqr_pkg::sqr_state_t state,
        input  logic rd_aj, rd_aiminusj, rd_ai, rd_mj, rd_niminusj, rd_n0,
        input  logic iloopa1_dly, oprnd2_load,
        input  logic wr_mi, wr_mlen, wr_next_mi, wr_next_mlen,
        output logic memren,
        output logic a_rd_sel, m_rd_sel, n_rd_sel, m_wr_sel,
        output logic iminus1_ptr_sel, j_ptr_sel, iminusj_ptr_sel,
        output logic iminuslenminus1_sel, irshft_sel,
        output logic oprnd2_wen, oprnd2_bypass,
        output ma_sqr_pkg::op1_sel_t oprnd1_mxsel,
        output logic oprnd1_wen
);

        logic idle, nprime, memrd4op1, memrd4op1_q, oprnd2_load_q;

        assign idle   = (state == ma_sqr_pkg::s_idle);
        assign nprime = (state == ma_sqr_pkg::s_nprime);

        // ------------------------------
        // memory selects
        // ------------------------------
        assign memren   = rd_aj | rd_aiminusj | rd_mj | rd_niminusj | rd_ai | rd_n0;
        assign a_rd_sel = rd_aj | rd_ai | rd_aiminusj;
        assign m_rd_sel = rd_mj;
        // M[j] wins over N[i-j] when both are up
        assign n_rd_sel = (rd_niminusj & ~rd_mj) | rd_n0;
        assign m_wr_sel = wr_mi | wr_mlen;

        // pointer selects
        assign iminus1_ptr_sel     = wr_mi;
        assign iminuslenminus1_sel = wr_mlen;
        assign j_ptr_sel           = rd_aj | rd_mj;
        assign iminusj_ptr_sel     = (rd_aiminusj | rd_niminusj) & ~(rd_aj | rd_mj);
        assign irshft_sel          = rd_ai;

        // ------------------------------
        // operand registers
        // ------------------------------
        // these reads go to operand 1, the rest to operand 2
        assign memrd4op1 = rd_aiminusj | iloopa1_dly | rd_niminusj | rd_n0;

        always_ff @(posedge rclk or negedge rst_n) begin
                if (!rst_n) begin
                        memrd4op1_q    <= 1'b0;
                        oprnd2_load_q  <= 1'b0;
                end else begin
                        memrd4op1_q    <= memrd4op1;
                        oprnd2_load_q  <= oprnd2_load;
                end
        end

        // write-back product goes straight into operand 2
        assign oprnd2_bypass = wr_next_mi | wr_next_mlen;
        // nothing loads in idle, an aborted read is dropped
        assign oprnd2_wen    = (oprnd2_load_q & ~idle) | oprnd2_bypass;
        assign oprnd1_wen    = memrd4op1_q & ~idle;

        assign oprnd1_mxsel[0] = ~nprime & ~idle & ~memrd4op1_q;
        assign oprnd1_mxsel[1] = ~nprime & ~idle & memrd4op1_q;

endmodule

// File: verilog/ma_sqr_pkg.sv
// shared types for the squaring sequencer (A equals B)
// state encoding is one-hot, bit order matches the fsm state register
package ma_sqr_pkg;

        // ------------------------------
        // loop states, one bit each
        // ------------------------------
        typedef enum logic [10:0] {
                // waiting for a start
                s_idle      = 11'h001,
                // read A[j]
                s_jloopa    = 11'h002,
                // read A[i-j], multiply
                s_ijloopa   = 11'h004,
                // read A[i/2]
                s_iloopa1   = 11'h008,
                // square multiply
                s_iloopa    = 11'h010,
                // read M[j]
                s_jloopm    = 11'h020,
                // read N[i-j], multiply
                s_jloopn    = 11'h040,
                // n-prime multiply
                s_nprime    = 11'h080,
                // write M
                s_mwrite    = 11'h100,
                // N[0] multiply
                s_iloopn    = 11'h200,
                // accumulator shift
                s_accumshft = 11'h400
        } sqr_state_t;

        // operand-1 mux select
        // bit 0 picks the previous product, bit 1 the memory word
        // both low in nprime
        typedef logic [1:0] op1_sel_t;

        // cycles from the final multiplier ack until the product can be written
        localparam int unsigned MUL_RES_DLY = 5;

endpackage

// File: verilog/ma_sqr_top.sv
// montgomery squaring sequencer, top level
// start needs iss_pulse_dly and mulop high with aequb seen the cycle before
// kill_op aborts on the next edge, no mul_done is given for a killed op
`timescale 1ns/1ps

module ma_sqr_top #(
        parameter int unsigned RES_DLY = ma_sqr_pkg::MUL_RES_DLY
) (
        input  logic rclk,
        input  logic rst_n,
        input  logic kill_op,
        input  logic mulop,
        input  logic iss_pulse_dly,
        input  logic aequb,
        // pointer unit flags, all levels
        input  logic iequtwolenplus2, iequtwolenplus1, iequtwolen,
        input  logic ieven, ieq0,
        input  logic jequiminus1, jequiminus1rshft, jequlen,
        input  logic halfpnt_set,
        // multiplier levels
        input  logic mul_ack,
        input  logic mul_shf_ack,
        // memory and pointer controls
        output logic memren, memwen,
        output logic rst_iptr, rst_jptr, incr_iptr, incr_jptr,
        output logic a_rd_sel, m_rd_sel, n_rd_sel, m_wr_sel,
        output logic iminus1_ptr_sel, j_ptr_sel, iminusj_ptr_sel,
        output logic iminuslenminus1_sel, irshft_sel,
        output logic jjptr_wen, jjptr_sel,
        // operand registers
        output logic oprnd2_wen, oprnd2_bypass, a_leftshft,
        output ma_sqr_pkg::op1_sel_t oprnd1_mxsel,
        output logic oprnd1_wen,
        // multiplier controls
        output logic mul_req_vld, mul_areg_shf, mul_acc, mul_areg_rst,
        output logic mul_done
);

        // execute to decode
        ma_sqr_pkg::sqr_state_t state;
        logic rd_aj, rd_aiminusj, rd_ai, rd_mj, rd_niminusj, rd_n0;
        logic iloopa1_dly, oprnd2_load;

        // execute and result
        logic jloopn_final, nprime_ack, accum_enter, accum_done;
        logic mwrite_next;

        // result to decode
        logic wr_mi, wr_mlen, wr_next_mi, wr_next_mlen;

        ma_sqr_fsm fsm_i (.*);

        ma_sqr_opsel opsel_i (.*);

        ma_sqr_wrback #(
                .RES_DLY (RES_DLY)
        ) wrback_i (.*);

endmodule

// File: verilog/ma_sqr_wrback.sv
// result stage, product delay line and M write-back
// RES_DLY of 1 or more; several acks may be in flight in the delay line
// write target follows halfpnt_set: M[i-1] before it, M[i-len-1] after
`timescale 1ns/1ps

module ma_sqr_wrback #(
        parameter int unsigned RES_DLY = ma_sqr_pkg::MUL_RES_DLY
) (
        input  logic rclk,
        input  logic rst_n,
        input  logic kill_op,
        input  logic halfpnt_set,
        input  logic jloopn_final,
        input  logic nprime_ack,
        input  logic accum_enter,
        input  logic accum_done,
        input  logic iequtwolenplus1,
        input  ma_sqr_pkg::sqr_state_t state,
        output logic mwrite_next,
        output logic wr_mi, wr_mlen, wr_next_mi, wr_next_mlen,
        output logic incr_iptr, rst_iptr,
        output logic memwen,
        output logic mul_done
);

        logic [RES_DLY-1:0] res_q;
        logic res_c0, accumshft_q, accum_exit, tr2mwrite_frm_accumshft;

        // product ready to be written RES_DLY cycles after these acks
        assign res_c0 = nprime_ack | jloopn_final;

        // accumshft left last cycle, i is not touched on the way out
        assign accum_exit = accumshft_q & (state != ma_sqr_pkg::s_accumshft);
        // last i pass skips the j loop, this extra cycle covers i-len-1
        assign tr2mwrite_frm_accumshft = accum_exit & iequtwolenplus1;

        always_ff @(posedge rclk or negedge rst_n) begin
                if (!rst_n) begin
                        res_q       <= '0;
                        accumshft_q <= 1'b0;
                        memwen      <= 1'b0;
                        mul_done    <= 1'b0;
                end else if (kill_op) begin
                        res_q       <= '0;
                        accumshft_q <= 1'b0;
                        memwen      <= 1'b0;
                        mul_done    <= 1'b0;
                end else begin
                        res_q       <= (res_q << 1) | RES_DLY'(res_c0);
                        accumshft_q <= (state == ma_sqr_pkg::s_accumshft);
                        // memory write lands the cycle after the i increment
                        memwen      <= incr_iptr;
                        mul_done    <= accum_done;
                end
        end

        // ------------------------------
        // M write split
        // ------------------------------
        assign mwrite_next  = res_q[RES_DLY-1] | tr2mwrite_frm_accumshft;
        assign wr_next_mi   = mwrite_next & ~halfpnt_set;
        assign wr_next_mlen = mwrite_next & halfpnt_set;
        assign wr_mi        = memwen & ~halfpnt_set;
        assign wr_mlen      = memwen & halfpnt_set;

        // i pointer steps on every accumshft entry, clears at the end
        assign incr_iptr = accum_enter;
        assign rst_iptr  = accum_done;

endmodule
